//--- logic/ctrl_unit_defines.svh
`ifndef CTRL_UNIT_DEFINES_SVH
`define CTRL_UNIT_DEFINES_SVH

// Instruction word and field widths
`define ILEN              32
`define OPCODE_LEN        7
`define FUNCT3_LEN        3
`define FUNCT7_LEN        7
`define EXC_CODE_LEN      4

// Major opcodes handled by the control unit
`define OPCODE_BRANCH     7'b1100011
`define OPCODE_LOAD       7'b0000011
`define OPCODE_STORE      7'b0100011
`define OPCODE_MISC_MEM   7'b0001111
`define OPCODE_SYSTEM     7'b1110011

// Branch funct3
`define FUNCT3_BEQ        3'b000
`define FUNCT3_BNE        3'b001
`define FUNCT3_BLT        3'b100
`define FUNCT3_BGE        3'b101
`define FUNCT3_BLTU       3'b110
`define FUNCT3_BGEU       3'b111

// Load funct3
`define FUNCT3_LB         3'b000
`define FUNCT3_LH         3'b001
`define FUNCT3_LW         3'b010
`define FUNCT3_LD         3'b011
`define FUNCT3_LBU        3'b100
`define FUNCT3_LHU        3'b101
`define FUNCT3_LWU        3'b110

// Store funct3
`define FUNCT3_SB         3'b000
`define FUNCT3_SH         3'b001
`define FUNCT3_SW         3'b010
`define FUNCT3_SD         3'b011

// Fences
`define FUNCT3_FENCE_I    3'b001
`define FUNCT3_SFENCE_VMA 3'b000
`define FUNCT7_SFENCE_VMA 7'b0001001

// Exception causes, privileged spec numbering
`define EXC_I_MISALIGNED  4'd0
`define EXC_I_ACCESS      4'd1
`define EXC_ILLEGAL       4'd2
`define EXC_LD_MISALIGNED 4'd4
`define EXC_LD_ACCESS     4'd5
`define EXC_ST_MISALIGNED 4'd6
`define EXC_ST_ACCESS     4'd7
`define EXC_ECALL_S       4'd9
`define EXC_ECALL_M       4'd11
`define EXC_I_PAGE_FAULT  4'd12
`define EXC_LD_PAGE_FAULT 4'd13
`define EXC_ST_PAGE_FAULT 4'd15

`endif

//--- logic/rv_isa_pkg.sv
`include "ctrl_unit_defines.svh"

package rv_isa_pkg;

	// Raw instruction word and its fields
	typedef logic [`ILEN-1:0]         instr_t;
	typedef logic [`OPCODE_LEN-1:0]   opcode_t;
	typedef logic [`FUNCT3_LEN-1:0]   funct3_t;
	typedef logic [`FUNCT7_LEN-1:0]   funct7_t;

	// Trap cause as seen by the control unit
	typedef logic [`EXC_CODE_LEN-1:0] except_code_t;

	// Comparison selected for the branch unit
	typedef enum logic [2:0] {
		BEQ,
		BNE,
		BLT,
		BLTU,
		BGE,
		BGEU
	} branch_type_e;

	// Access size and sign handling for the load/store unit
	typedef enum logic [2:0] {
		LS_BYTE,
		LS_BYTE_U,
		LS_HALFWORD,
		LS_HALFWORD_U,
		LS_WORD,
		LS_WORD_U,
		LS_DOUBLEWORD
	} ldst_type_e;

endpackage

//--- logic/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

	// Flush request sent to both TLB levels
	typedef enum logic [1:0] {
		NO_FLUSH,
		FLUSH_ALL,
		FLUSH_ASID,
		FLUSH_PAGE
	} tlb_flush_e;

	// Pipeline control FSM states
	typedef enum logic [2:0] {
		ST_RESET,
		ST_RUN,
		ST_STALL,
		ST_IMEM_EXCEPT,
		ST_EXCEPT_FLUSH
	} pipe_state_e;

endpackage

//--- logic/instr_decoder.sv
`timescale 1ns/1ns
`include "ctrl_unit_defines.svh"

module instr_decoder (
	input  rv_isa_pkg::instr_t       instr_i,
	output rv_isa_pkg::branch_type_e branch_type_o,
	output rv_isa_pkg::ldst_type_e   ldst_type_o,
	output logic                     fence_i_o,
	output logic                     sfence_vma_o
);

	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::funct3_t funct3;
	rv_isa_pkg::funct7_t funct7;

	assign opcode = instr_i[`OPCODE_LEN-1:0];
	// funct3 sits right above rd
	assign funct3 = instr_i[12 +: `FUNCT3_LEN];
	assign funct7 = instr_i[`ILEN-1 -: `FUNCT7_LEN];

	// Branch comparison, BEQ when not a branch
	always_comb begin
		branch_type_o = rv_isa_pkg::BEQ;
		if (opcode == `OPCODE_BRANCH) begin
			case (funct3)
				`FUNCT3_BNE:  branch_type_o = rv_isa_pkg::BNE;
				`FUNCT3_BLT:  branch_type_o = rv_isa_pkg::BLT;
				`FUNCT3_BGE:  branch_type_o = rv_isa_pkg::BGE;
				`FUNCT3_BLTU: branch_type_o = rv_isa_pkg::BLTU;
				`FUNCT3_BGEU: branch_type_o = rv_isa_pkg::BGEU;
				default:      branch_type_o = rv_isa_pkg::BEQ;
			endcase
		end
	end

	// Access size, word when not a known load or store
	always_comb begin
		ldst_type_o = rv_isa_pkg::LS_WORD;
		if (opcode == `OPCODE_LOAD) begin
			case (funct3)
				`FUNCT3_LB:  ldst_type_o = rv_isa_pkg::LS_BYTE;
				`FUNCT3_LH:  ldst_type_o = rv_isa_pkg::LS_HALFWORD;
				`FUNCT3_LD:  ldst_type_o = rv_isa_pkg::LS_DOUBLEWORD;
				`FUNCT3_LBU: ldst_type_o = rv_isa_pkg::LS_BYTE_U;
				`FUNCT3_LHU: ldst_type_o = rv_isa_pkg::LS_HALFWORD_U;
				`FUNCT3_LWU: ldst_type_o = rv_isa_pkg::LS_WORD_U;
				default:     ldst_type_o = rv_isa_pkg::LS_WORD;
			endcase
		end else if (opcode == `OPCODE_STORE) begin
			case (funct3)
				`FUNCT3_SB: ldst_type_o = rv_isa_pkg::LS_BYTE;
				`FUNCT3_SH: ldst_type_o = rv_isa_pkg::LS_HALFWORD;
				`FUNCT3_SD: ldst_type_o = rv_isa_pkg::LS_DOUBLEWORD;
				default:    ldst_type_o = rv_isa_pkg::LS_WORD;
			endcase
		end
	end

	// Fence detection for the maintenance block
	assign fence_i_o = (opcode == `OPCODE_MISC_MEM) && (funct3 == `FUNCT3_FENCE_I);

	assign sfence_vma_o = (opcode == `OPCODE_SYSTEM)
		&& (funct3 == `FUNCT3_SFENCE_VMA)
		&& (funct7 == `FUNCT7_SFENCE_VMA);

endmodule

//--- logic/pipe_ctrl_fsm.sv
`timescale 1ns/1ns

module pipe_ctrl_fsm (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic main_stall_i,
	input  logic imem_except_i,
	input  logic except_raised_i,
	output logic stall_o,
	output logic flush_o
);

	mem_ctrl_pkg::pipe_state_e state_q;
	mem_ctrl_pkg::pipe_state_e state_d;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= mem_ctrl_pkg::ST_RESET;
		end else begin
			state_q <= state_d;
		end
	end

	// Same priority from every state
	always_comb begin
		if (imem_except_i) begin
			state_d = mem_ctrl_pkg::ST_IMEM_EXCEPT;
		end else if (except_raised_i) begin
			state_d = mem_ctrl_pkg::ST_EXCEPT_FLUSH;
		end else if (main_stall_i) begin
			state_d = mem_ctrl_pkg::ST_STALL;
		end else begin
			state_d = mem_ctrl_pkg::ST_RUN;
		end
	end

	// Moore outputs
	always_comb begin
		stall_o = 1'b0;
		flush_o = 1'b0;
		case (state_q)
			mem_ctrl_pkg::ST_RESET:        flush_o = 1'b1;
			mem_ctrl_pkg::ST_STALL:        stall_o = 1'b1;
			// Fetch waits for the I-cache to recover
			mem_ctrl_pkg::ST_IMEM_EXCEPT:  stall_o = 1'b1;
			mem_ctrl_pkg::ST_EXCEPT_FLUSH: flush_o = 1'b1;
			default: begin
				stall_o = 1'b0;
				flush_o = 1'b0;
			end
		endcase
	end

endmodule

//--- logic/mem_maint_ctrl.sv
`timescale 1ns/1ns
`include "ctrl_unit_defines.svh"

module mem_maint_ctrl (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     fence_i_i,
	input  logic                     sfence_vma_i,
	input  logic                     imem_except_i,
	input  logic                     except_raised_i,
	input  rv_isa_pkg::except_code_t except_code_i,
	input  logic                     l2c_update_done_i,
	output logic                     abort_o,
	output logic                     clr_l1tlb_mshr_o,
	output logic                     clr_l2tlb_mshr_o,
	output logic                     clr_dmshr_o,
	output logic                     synch_l1dc_l2c_o,
	output mem_ctrl_pkg::tlb_flush_e tlb_flush_type_o
);

	logic exc_instr;
	logic exc_ldst;
	logic exc_page;
	logic exc_illegal;
	logic exc_ecall;

	logic abort_d, clr_tlb_d, clr_dmshr_d, synch_d;
	logic abort_q, clr_tlb_q, clr_dmshr_q, synch_q;
	mem_ctrl_pkg::tlb_flush_e flush_type_d;
	mem_ctrl_pkg::tlb_flush_e flush_type_q;

	// Cause classes
	assign exc_instr = (except_code_i == `EXC_I_MISALIGNED) || (except_code_i == `EXC_I_ACCESS)
		|| (except_code_i == `EXC_I_PAGE_FAULT);
	assign exc_ldst = (except_code_i == `EXC_LD_MISALIGNED) || (except_code_i == `EXC_LD_ACCESS)
		|| (except_code_i == `EXC_ST_MISALIGNED) || (except_code_i == `EXC_ST_ACCESS)
		|| (except_code_i == `EXC_LD_PAGE_FAULT) || (except_code_i == `EXC_ST_PAGE_FAULT);
	assign exc_page = (except_code_i == `EXC_I_PAGE_FAULT)
		|| (except_code_i == `EXC_LD_PAGE_FAULT) || (except_code_i == `EXC_ST_PAGE_FAULT);
	assign exc_illegal = (except_code_i == `EXC_ILLEGAL);
	assign exc_ecall = (except_code_i == `EXC_ECALL_S) || (except_code_i == `EXC_ECALL_M);

	// First matching command wins
	always_comb begin
		abort_d     = 1'b0;
		clr_tlb_d   = 1'b0;
		clr_dmshr_d = 1'b0;
		synch_d     = 1'b0;
		if (fence_i_i) begin
			clr_tlb_d = 1'b1;
		end else if (sfence_vma_i && !l2c_update_done_i) begin
			clr_tlb_d   = 1'b1;
			clr_dmshr_d = 1'b1;
			synch_d     = 1'b1;
		end else if (except_raised_i && exc_instr) begin
			clr_tlb_d = 1'b1;
		end else if (except_raised_i && exc_ldst) begin
			clr_dmshr_d = 1'b1;
		end else if (except_raised_i && exc_illegal) begin
			abort_d = 1'b1;
		end else if (except_raised_i && exc_ecall && !l2c_update_done_i) begin
			synch_d = 1'b1;
		end
	end

	// TLB flush kind
	always_comb begin
		if (imem_except_i) begin
			flush_type_d = mem_ctrl_pkg::FLUSH_ASID;
		end else if (except_raised_i && exc_page) begin
			flush_type_d = mem_ctrl_pkg::FLUSH_PAGE;
		end else if (except_raised_i) begin
			flush_type_d = mem_ctrl_pkg::FLUSH_ALL;
		end else begin
			flush_type_d = mem_ctrl_pkg::NO_FLUSH;
		end
	end

	// Out of reset the MSHRs are cleared and both TLBs flushed
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			abort_q      <= 1'b0;
			clr_tlb_q    <= 1'b1;
			clr_dmshr_q  <= 1'b1;
			synch_q      <= 1'b0;
			flush_type_q <= mem_ctrl_pkg::FLUSH_ALL;
		end else begin
			abort_q      <= abort_d;
			clr_tlb_q    <= clr_tlb_d;
			clr_dmshr_q  <= clr_dmshr_d;
			synch_q      <= synch_d;
			flush_type_q <= flush_type_d;
		end
	end

	assign abort_o          = abort_q;
	// Both TLB levels always get the same clear
	assign clr_l1tlb_mshr_o = clr_tlb_q;
	assign clr_l2tlb_mshr_o = clr_tlb_q;
	assign clr_dmshr_o      = clr_dmshr_q;
	assign synch_l1dc_l2c_o = synch_q;
	assign tlb_flush_type_o = flush_type_q;

endmodule

//--- logic/ctrl_unit.sv
`timescale 1ns/1ns

module ctrl_unit (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  rv_isa_pkg::instr_t       instr_i,
	input  logic                     main_stall_i,
	input  logic                     imem_except_i,
	input  logic                     except_raised_i,
	input  rv_isa_pkg::except_code_t except_code_i,
	input  logic                     l2c_update_done_i,
	output rv_isa_pkg::branch_type_e branch_type_o,
	output rv_isa_pkg::ldst_type_e   ldst_type_o,
	output logic                     stall_o,
	output logic                     flush_o,
	output logic                     abort_o,
	output logic                     clr_l1tlb_mshr_o,
	output logic                     clr_l2tlb_mshr_o,
	output logic                     clr_dmshr_o,
	output logic                     synch_l1dc_l2c_o,
	output mem_ctrl_pkg::tlb_flush_e tlb_flush_type_o
);

	// Fence flags from decode to maintenance
	logic fence_i;
	logic sfence_vma;

	instr_decoder i_instr_decoder (
		.instr_i       (instr_i),
		.branch_type_o (branch_type_o),
		.ldst_type_o   (ldst_type_o),
		.fence_i_o     (fence_i),
		.sfence_vma_o  (sfence_vma)
	);

	pipe_ctrl_fsm i_pipe_ctrl_fsm (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.main_stall_i    (main_stall_i),
		.imem_except_i   (imem_except_i),
		.except_raised_i (except_raised_i),
		.stall_o         (stall_o),
		.flush_o         (flush_o)
	);

	mem_maint_ctrl i_mem_maint_ctrl (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.fence_i_i         (fence_i),
		.sfence_vma_i      (sfence_vma),
		.imem_except_i     (imem_except_i),
		.except_raised_i   (except_raised_i),
		.except_code_i     (except_code_i),
		.l2c_update_done_i (l2c_update_done_i),
		.abort_o           (abort_o),
		.clr_l1tlb_mshr_o  (clr_l1tlb_mshr_o),
		.clr_l2tlb_mshr_o  (clr_l2tlb_mshr_o),
		.clr_dmshr_o       (clr_dmshr_o),
		.synch_l1dc_l2c_o  (synch_l1dc_l2c_o),
		.tlb_flush_type_o  (tlb_flush_type_o)
	);

endmodule

//--- sim/ctrl_unit_chk.sv
`timescale 1ns/1ns
`include "ctrl_unit_defines.svh"

module ctrl_unit_chk (
	input logic                     clk_i,
	input logic                     rst_n_i,
	input rv_isa_pkg::instr_t       instr_i,
	input logic                     main_stall_i,
	input logic                     imem_except_i,
	input logic                     except_raised_i,
	input rv_isa_pkg::except_code_t except_code_i,
	input logic                     l2c_update_done_i,
	input logic                     stall_i,
	input logic                     flush_i,
	input logic                     abort_i,
	input logic                     clr_l1tlb_mshr_i,
	input logic                     clr_l2tlb_mshr_i,
	input logic                     clr_dmshr_i,
	input logic                     synch_l1dc_l2c_i,
	input mem_ctrl_pkg::tlb_flush_e tlb_flush_type_i
);

	int unsigned err_cnt = 0;

	logic is_fence_i, is_sfence, stall_exp, flush_exp;
	// {tlb clears, dmshr clear, abort, sync}
	logic [3:0] cmd_exp;
	mem_ctrl_pkg::tlb_flush_e flush_type_exp;

	assign is_fence_i = (instr_i[6:0] == `OPCODE_MISC_MEM) && (instr_i[14:12] == `FUNCT3_FENCE_I);
	assign is_sfence = (instr_i[6:0] == `OPCODE_SYSTEM) && (instr_i[14:12] == `FUNCT3_SFENCE_VMA)
		&& (instr_i[31:25] == `FUNCT7_SFENCE_VMA);
	assign stall_exp = imem_except_i || (!except_raised_i && main_stall_i);
	assign flush_exp = !imem_except_i && except_raised_i;

	always_comb begin
		cmd_exp = 4'b0000;
		if (is_fence_i) begin
			cmd_exp = 4'b1000;
		end else if (is_sfence && !l2c_update_done_i) begin
			cmd_exp = 4'b1101;
		end else if (except_raised_i) begin
			case (except_code_i)
				4'd0, 4'd1, 4'd12:             cmd_exp = 4'b1000;
				4'd4, 4'd5, 4'd6, 4'd7, 4'd13, 4'd15: cmd_exp = 4'b0100;
				4'd2:                          cmd_exp = 4'b0010;
				4'd9, 4'd11:                   cmd_exp = {3'b000, !l2c_update_done_i};
				default:                       cmd_exp = 4'b0000;
			endcase
		end
	end

	always_comb begin
		if (imem_except_i) begin
			flush_type_exp = mem_ctrl_pkg::FLUSH_ASID;
		end else if (except_raised_i && (except_code_i inside {4'd12, 4'd13, 4'd15})) begin
			flush_type_exp = mem_ctrl_pkg::FLUSH_PAGE;
		end else if (except_raised_i) begin
			flush_type_exp = mem_ctrl_pkg::FLUSH_ALL;
		end else begin
			flush_type_exp = mem_ctrl_pkg::NO_FLUSH;
		end
	end

	// Reset values hold through reset and one cycle beyond
	a_reset: assert property (@(posedge clk_i) (!rst_n_i || !$past(rst_n_i)) |->
		(flush_i && !stall_i && clr_l1tlb_mshr_i && clr_l2tlb_mshr_i && clr_dmshr_i
		&& !abort_i && !synch_l1dc_l2c_i && (tlb_flush_type_i == mem_ctrl_pkg::FLUSH_ALL)))
		else begin err_cnt++; $error("outputs differ from reset values"); end

	a_pipe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$past(rst_n_i) |-> (stall_i == $past(stall_exp)) && (flush_i == $past(flush_exp)))
		else begin err_cnt++; $error("stall or flush does not follow the inputs"); end

	// Both TLB levels take the same expected clear
	a_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i) $past(rst_n_i) |->
		({clr_l1tlb_mshr_i, clr_dmshr_i, abort_i, synch_l1dc_l2c_i} == $past(cmd_exp))
		&& (clr_l2tlb_mshr_i == $past(cmd_exp[3])))
		else begin err_cnt++; $error("maintenance command wrong"); end

	a_flush_type: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$past(rst_n_i) |-> (tlb_flush_type_i == $past(flush_type_exp)))
		else begin err_cnt++; $error("TLB flush type wrong"); end

endmodule

bind ctrl_unit ctrl_unit_chk i_ctrl_unit_chk (
	.clk_i             (clk_i),
	.rst_n_i           (rst_n_i),
	.instr_i           (instr_i),
	.main_stall_i      (main_stall_i),
	.imem_except_i     (imem_except_i),
	.except_raised_i   (except_raised_i),
	.except_code_i     (except_code_i),
	.l2c_update_done_i (l2c_update_done_i),
	.stall_i           (stall_o),
	.flush_i           (flush_o),
	.abort_i           (abort_o),
	.clr_l1tlb_mshr_i  (clr_l1tlb_mshr_o),
	.clr_l2tlb_mshr_i  (clr_l2tlb_mshr_o),
	.clr_dmshr_i       (clr_dmshr_o),
	.synch_l1dc_l2c_i  (synch_l1dc_l2c_o),
	.tlb_flush_type_i  (tlb_flush_type_o)
);

//--- sim/tb_ctrl_unit.sv
`timescale 1ns/1ns
`include "ctrl_unit_defines.svh"

module tb_ctrl_unit;

	// Roughly ten times the stimulus length
	localparam int unsigned MAX_CYCLES = 2000;
	localparam rv_isa_pkg::instr_t NOP_WORD = 32'h0000_0013;
	localparam rv_isa_pkg::instr_t FENCE_I_WORD = {17'h0, `FUNCT3_FENCE_I, 5'h0, `OPCODE_MISC_MEM};
	localparam rv_isa_pkg::instr_t SFENCE_WORD =
		{`FUNCT7_SFENCE_VMA, 10'h0, `FUNCT3_SFENCE_VMA, 5'h0, `OPCODE_SYSTEM};

	logic clk_i, rst_n_i;
	rv_isa_pkg::instr_t instr_i;
	logic main_stall_i, imem_except_i, except_raised_i, l2c_update_done_i;
	rv_isa_pkg::except_code_t except_code_i;
	rv_isa_pkg::branch_type_e branch_type_o;
	rv_isa_pkg::ldst_type_e ldst_type_o;
	logic stall_o, flush_o, abort_o, clr_l1tlb_mshr_o, clr_l2tlb_mshr_o, clr_dmshr_o;
	logic synch_l1dc_l2c_o;
	mem_ctrl_pkg::tlb_flush_e tlb_flush_type_o;

	logic [31:0] lcg_state;
	int unsigned cycle_cnt = 0;
	int unsigned n_pass = 0;
	int unsigned n_fail = 0;
	int unsigned decode_errs;
	int unsigned chk_base;
	string test_name;

	ctrl_unit i_ctrl_unit (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Reference decode tables
	function automatic rv_isa_pkg::branch_type_e ref_branch(input rv_isa_pkg::opcode_t op,
		input rv_isa_pkg::funct3_t f3);
		if (op != `OPCODE_BRANCH) return rv_isa_pkg::BEQ;
		case (f3)
			`FUNCT3_BNE:  return rv_isa_pkg::BNE;
			`FUNCT3_BLT:  return rv_isa_pkg::BLT;
			`FUNCT3_BGE:  return rv_isa_pkg::BGE;
			`FUNCT3_BLTU: return rv_isa_pkg::BLTU;
			`FUNCT3_BGEU: return rv_isa_pkg::BGEU;
			default:      return rv_isa_pkg::BEQ;
		endcase
	endfunction

	function automatic rv_isa_pkg::ldst_type_e ref_ldst(input rv_isa_pkg::opcode_t op,
		input rv_isa_pkg::funct3_t f3);
		if (op != `OPCODE_LOAD && op != `OPCODE_STORE) return rv_isa_pkg::LS_WORD;
		// Stores only know the four signed sizes
		if (op == `OPCODE_STORE && f3[2]) return rv_isa_pkg::LS_WORD;
		case (f3)
			3'b000:  return rv_isa_pkg::LS_BYTE;
			3'b001:  return rv_isa_pkg::LS_HALFWORD;
			3'b011:  return rv_isa_pkg::LS_DOUBLEWORD;
			3'b100:  return rv_isa_pkg::LS_BYTE_U;
			3'b101:  return rv_isa_pkg::LS_HALFWORD_U;
			3'b110:  return rv_isa_pkg::LS_WORD_U;
			default: return rv_isa_pkg::LS_WORD;
		endcase
	endfunction

	task automatic drive_quiet();
		instr_i = NOP_WORD;
		main_stall_i = 1'b0;
		imem_except_i = 1'b0;
		except_raised_i = 1'b0;
		except_code_i = '0;
		l2c_update_done_i = 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		decode_errs = 0;
		chk_base = i_ctrl_unit.i_ctrl_unit_chk.err_cnt;
	endtask

	// Extra quiet cycle so the checks on the last input land in this test
	task automatic close_test();
		int unsigned errs;
		@(negedge clk_i);
		drive_quiet();
		@(posedge clk_i);
		#1;
		errs = decode_errs + (i_ctrl_unit.i_ctrl_unit_chk.err_cnt - chk_base);
		if (errs == 0) begin
			n_pass++;
			$display("%s: passed", test_name);
		end else begin
			n_fail++;
			$display("%s: failed with %0d errors", test_name, errs);
		end
	endtask

	task automatic check_decode(input rv_isa_pkg::opcode_t op, input rv_isa_pkg::funct3_t f3);
		rv_isa_pkg::branch_type_e exp_br;
		rv_isa_pkg::ldst_type_e exp_ls;
		exp_br = ref_branch(op, f3);
		exp_ls = ref_ldst(op, f3);
		@(negedge clk_i);
		instr_i = {lcg_state[31:15], f3, lcg_state[11:7], op};
		#1;
		assert (branch_type_o == exp_br) else begin
			$display("Error %s: branch type expected %s, actual %s", test_name,
				exp_br.name(), branch_type_o.name());
			decode_errs++;
		end
		assert (ldst_type_o == exp_ls) else begin
			$display("Error %s: ldst type expected %s, actual %s", test_name,
				exp_ls.name(), ldst_type_o.name());
			decode_errs++;
		end
	endtask

	initial begin
		rv_isa_pkg::opcode_t op;
		lcg_state = 32'hd558_2ee6;
		rst_n_i = 1'b1;
		drive_quiet();
		#2 rst_n_i = 1'b0;

		begin_test("reset");
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		repeat (3) @(negedge clk_i);
		close_test();

		begin_test("decode");
		for (int i = 0; i < 48; i++) begin
			lcg_state = lcg_next(lcg_state);
			case (lcg_state[21:20])
				2'd0:    op = `OPCODE_BRANCH;
				2'd1:    op = `OPCODE_LOAD;
				2'd2:    op = `OPCODE_STORE;
				default: op = lcg_state[6:0];
			endcase
			check_decode(op, lcg_state[14:12]);
		end
		close_test();

		begin_test("fences");
		@(negedge clk_i);
		instr_i = FENCE_I_WORD;
		@(negedge clk_i);
		instr_i = SFENCE_WORD;
		@(negedge clk_i);
		l2c_update_done_i = 1'b1;
		close_test();

		// Every cause, first with the L2 sync pending, then with it done
		begin_test("exceptions");
		for (int c = 0; c < 32; c++) begin
			@(negedge clk_i);
			except_raised_i = 1'b1;
			except_code_i = rv_isa_pkg::except_code_t'(c % 16);
			l2c_update_done_i = (c >= 16);
		end
		close_test();

		begin_test("mixed");
		for (int i = 0; i < 24; i++) begin
			lcg_state = lcg_next(lcg_state);
			@(negedge clk_i);
			instr_i = lcg_state[29] ? (lcg_state[30] ? FENCE_I_WORD : SFENCE_WORD) : NOP_WORD;
			except_raised_i = lcg_state[16];
			except_code_i = lcg_state[27:24];
			l2c_update_done_i = lcg_state[20];
		end
		close_test();

		begin_test("pipeline");
		for (int p = 0; p < 8; p++) begin
			@(negedge clk_i);
			{imem_except_i, except_raised_i, main_stall_i} = 3'(p);
		end
		close_test();

		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- ctrl_unit.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/mem_ctrl_pkg.sv
logic/instr_decoder.sv
logic/pipe_ctrl_fsm.sv
logic/mem_maint_ctrl.sv
logic/ctrl_unit.sv
sim/ctrl_unit_chk.sv
sim/tb_ctrl_unit.sv

//--- Makefile
TOP := tb_ctrl_unit
LOG := sim.log

.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f ctrl_unit.f -o $(TOP)

run:
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f ctrl_unit.f

clean:
	rm -rf obj_dir $(LOG)
